// ==== src.f ====
+incdir+hdl
hdl/wbuf_pkg.sv
hdl/sync_fifo_afe.sv
hdl/wbuf_intake.sv
hdl/wbuf_drain.sv
hdl/wbuf_top.sv
verif/wbuf_tb_mem.sv
verif/wbuf_tb.sv

// ==== verif/wbuf_tb.sv ====
// Write buffer testbench with seeded random stores checked against a byte model of memory.
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module wbuf_tb;

	logic                 clk;
	logic                 reset_n;
	logic                 st;
	wbuf_pkg::store_req_t st_req;
	logic                 stall;
	logic                 overflow_err;
	logic                 mem_wr;
	wbuf_pkg::mem_wr_t    mem_req;
	logic                 mem_ack;
	logic                 hold;
	logic [7:0]           model [64];
	integer               seed;
	integer               write_count;
	integer               prev_count;
	logic                 prev_wr;
	wbuf_pkg::mem_wr_t    prev_req;

	wbuf_top u_dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.st           (st),
		.st_req       (st_req),
		.stall        (stall),
		.overflow_err (overflow_err),
		.mem_wr       (mem_wr),
		.mem_req      (mem_req),
		.mem_ack      (mem_ack)
	);

	wbuf_tb_mem u_mem (
		.clk     (clk),
		.reset_n (reset_n),
		.hold    (hold),
		.mem_wr  (mem_wr),
		.mem_req (mem_req),
		.mem_ack (mem_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check(input logic [127:0] actual, input logic [127:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s.", $time, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_n = 1'b0;
		st = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	endtask

	// drained means mem_wr has stayed low longer than a load followed by a merge
	// of every FIFO entry can take.
	task automatic wait_drained();
		integer quiet;
		integer cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < `WBUF_DEPTH + 4) begin
			@(negedge clk);
			cycles = cycles + 1;
			quiet = mem_wr ? 0 : quiet + 1;
			if (cycles > 2000) begin
				abort_on_timeout("the write buffer to drain");
			end
		end
	endtask

	task automatic drive_store(input logic [29:0] addr);
		st_req.addr = addr;
		st_req.data = $random(seed);
		st_req.be = $random(seed);
		st = 1'b1;
	endtask

	always @(posedge clk) begin
		if (reset_n && mem_wr && mem_ack) begin
			write_count = write_count + 1;
		end
	end

	// a held request must not move until its acknowledge has been taken.
	always @(negedge clk) begin
		if (reset_n && prev_wr && mem_wr && write_count == prev_count) begin
			check(mem_req, prev_req, "mem_req changed while mem_wr was held");
		end
		prev_wr = mem_wr;
		prev_req = mem_req;
		prev_count = write_count;
	end

	initial begin
		integer      i;
		integer      sent;
		integer      store_count;
		integer      addr_changes;
		logic [29:0] last_addr;
		seed = 32'h863;
		write_count = 0;
		prev_count = 0;
		prev_wr = 1'b0;
		prev_req = '0;
		store_count = 0;
		addr_changes = 0;
		last_addr = '0;
		reset_n = 1'b0;
		st = 1'b0;
		st_req = '0;
		hold = 1'b0;
		for (i = 0; i < 64; i++) begin
			model[i] = 8'h00;
		end
		apply_reset();
		check(stall, 1'b0, "stall after reset");
		check(overflow_err, 1'b0, "overflow_err after reset");
		check(mem_wr, 1'b0, "mem_wr after reset");

		// four word addresses keep merges frequent.
		for (i = 0; i < 300; i++) begin
			@(negedge clk);
			st = 1'b0;
			if (!stall && ($random(seed) & 1)) begin
				drive_store(30'({$random(seed)} % 4));
				if (store_count > 0 && st_req.addr != last_addr) begin
					addr_changes = addr_changes + 1;
				end
				last_addr = st_req.addr;
				store_count = store_count + 1;
				for (int b = 0; b < 4; b++) begin
					if (st_req.be[b]) begin
						model[4 * st_req.addr[3:0] + b] = st_req.data[8*b +: 8];
					end
				end
			end
		end
		@(negedge clk);
		st = 1'b0;
		wait_drained();
		for (i = 0; i < 64; i++) begin
			check(u_mem.image[i], model[i], $sformatf("memory image byte %0d", i));
		end
		check(write_count <= store_count, 1'b1, "more memory writes than stores");
		check(write_count >= addr_changes + 1, 1'b1, "fewer memory writes than address runs");

		// back-pressure with distinct addresses while the responder holds off.
		hold = 1'b1;
		@(negedge clk);
		for (sent = 0; sent < `WBUF_DEPTH + 2 && !stall; sent++) begin
			drive_store(30'h10 + 30'(sent));
			@(negedge clk);
			st = 1'b0;
		end
		check(stall, 1'b1, "stall under back-pressure");
		check(overflow_err, 1'b0, "overflow_err under back-pressure");

		// keep storing into the stalled buffer until a store is lost.
		i = 0;
		while (!overflow_err) begin
			if (i == 2 * `WBUF_DEPTH) begin
				abort_on_timeout("overflow_err after storing into a full FIFO");
			end
			drive_store(30'h20 + 30'(i));
			@(negedge clk);
			st = 1'b0;
			i = i + 1;
		end
		repeat (10) begin
			@(negedge clk);
			check(overflow_err, 1'b1, "overflow_err sticky while stalled");
		end
		hold = 1'b0;
		wait_drained();
		check(overflow_err, 1'b1, "overflow_err sticky after draining");
		apply_reset();
		check(overflow_err, 1'b0, "overflow_err after second reset");
		check(stall, 1'b0, "stall after second reset");
		check(mem_wr, 1'b0, "mem_wr after second reset");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== verif/wbuf_tb_mem.sv ====
// Memory responder model that acknowledges held writes after a random delay and keeps a byte image.
`timescale 1ns/1ps

module wbuf_tb_mem (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              hold,
	input  logic              mem_wr,
	input  wbuf_pkg::mem_wr_t mem_req,
	output logic              mem_ack
);

	// sixteen words, indexed by the low four address bits and the byte lane.
	logic [7:0] image [64];
	integer     seed;
	integer     delay;

	initial begin
		seed = 32'h863;
		delay = -1;
		mem_ack = 1'b0;
		for (int i = 0; i < 64; i++) begin
			image[i] = 8'h00;
		end
	end

	// the acknowledge is driven on the falling edge and lasts one cycle.
	always @(negedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mem_ack <= 1'b0;
			delay = -1;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
		end else if (mem_wr && !hold) begin
			if (delay < 0) begin
				delay = {$random(seed)} % 6;
			end
			if (delay == 0) begin
				for (int b = 0; b < 4; b++) begin
					if (mem_req.be[b]) begin
						image[4 * mem_req.addr[3:0] + b] = mem_req.data[8*b +: 8];
					end
				end
				mem_ack <= 1'b1;
				delay = -1;
			end else begin
				delay = delay - 1;
			end
		end
	end

endmodule

// ==== hdl/wbuf_top.sv ====
// Store write buffer top level joining the intake, the FIFO and the drain.
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module wbuf_top (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 st,
	input  wbuf_pkg::store_req_t st_req,
	output logic                 stall,
	output logic                 overflow_err,
	output logic                 mem_wr,
	output wbuf_pkg::mem_wr_t    mem_req,
	input  logic                 mem_ack
);

	wbuf_pkg::store_req_t wr_data;
	wbuf_pkg::store_req_t rd_data;
	logic                 wr;
	logic                 rd;
	logic                 full;
	logic                 almost_full;
	logic                 empty;

	wbuf_intake u_intake (
		.clk          (clk),
		.reset_n      (reset_n),
		.st           (st),
		.st_req       (st_req),
		.full         (full),
		.almost_full  (almost_full),
		.wr           (wr),
		.wr_data      (wr_data),
		.stall        (stall),
		.overflow_err (overflow_err)
	);

	sync_fifo_afe #(
		.payload_t              (wbuf_pkg::store_req_t),
		.depth                  (`WBUF_DEPTH),
		.almost_full_threshold  (`WBUF_AF_THRESHOLD),
		.almost_empty_threshold (`WBUF_AE_THRESHOLD)
	) u_fifo (
		.clk          (clk),
		.reset_n      (reset_n),
		.wr           (wr),
		.wr_data      (wr_data),
		.rd           (rd),
		.rd_data      (rd_data),
		.empty        (empty),
		.full         (full),
		.almost_empty (),
		.almost_full  (almost_full)
	);

	wbuf_drain u_drain (
		.clk     (clk),
		.reset_n (reset_n),
		.rd_data (rd_data),
		.empty   (empty),
		.rd      (rd),
		.mem_wr  (mem_wr),
		.mem_req (mem_req),
		.mem_ack (mem_ack)
	);

endmodule

// ==== hdl/wbuf_drain.sv ====
// Write buffer drain: merges same-address stores and issues them as held memory writes.
`timescale 1ns/1ps

module wbuf_drain (
	input  logic                 clk,
	input  logic                 reset_n,
	input  wbuf_pkg::store_req_t rd_data,
	input  logic                 empty,
	output logic                 rd,
	output logic                 mem_wr,
	output wbuf_pkg::mem_wr_t    mem_req,
	input  logic                 mem_ack
);

	wbuf_pkg::mem_wr_t stg_q;
	wbuf_pkg::mem_wr_t stg_d;
	logic              stg_valid;
	logic              head_hit;
	logic              load;
	logic              merge;

	assign head_hit = !empty && (rd_data.addr == stg_q.addr);

	// staging takes the head when idle, and keeps absorbing matching heads until issued.
	assign load  = !stg_valid && !empty;
	assign merge = stg_valid && !mem_wr && head_hit;
	assign rd    = load | merge;

	always_comb begin
		stg_d = stg_q;
		if (load) begin
			stg_d.addr = rd_data.addr;
			stg_d.data = rd_data.data;
			stg_d.be   = rd_data.be;
		end else if (merge) begin
			// newer bytes overwrite older ones.
			for (int i = 0; i < $bits(rd_data.be); i++) begin
				if (rd_data.be[i]) begin
					stg_d.data[8*i +: 8] = rd_data.data[8*i +: 8];
				end
			end
			stg_d.be = stg_q.be | rd_data.be;
		end
	end

	always_ff @(posedge clk) begin
		stg_q <= stg_d;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			stg_valid <= 1'b0;
			mem_wr    <= 1'b0;
		end else if (mem_wr) begin
			if (mem_ack) begin
				stg_valid <= 1'b0;
				mem_wr    <= 1'b0;
			end
		end else if (load) begin
			stg_valid <= 1'b1;
		end else if (stg_valid && !head_hit) begin
			// nothing left to merge, so the write goes out.
			mem_wr <= 1'b1;
		end
	end

	// staging is frozen while mem_wr is high, which holds the request stable.
	assign mem_req = stg_q;

endmodule

// ==== hdl/wbuf_intake.sv ====
// Write buffer intake: registers core stores, pushes them into the FIFO and flags overflow.
`timescale 1ns/1ps

module wbuf_intake (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 st,
	input  wbuf_pkg::store_req_t st_req,
	input  logic                 full,
	input  logic                 almost_full,
	output logic                 wr,
	output wbuf_pkg::store_req_t wr_data,
	output logic                 stall,
	output logic                 overflow_err
);

	// set for the one cycle after a store strobe while the store sits in wr_data.
	logic pend;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pend <= 1'b0;
		end else begin
			pend <= st;
		end
	end

	always_ff @(posedge clk) begin
		if (st) begin
			wr_data <= st_req;
		end
	end

	assign wr = pend && !full;

	// a held store that meets a full FIFO is lost, and the error stays until reset.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			overflow_err <= 1'b0;
		end else if (pend && full) begin
			overflow_err <= 1'b1;
		end
	end

	assign stall = almost_full | full;

endmodule

// ==== hdl/sync_fifo_afe.sv ====
// Synchronous FIFO with registered empty, full, almost-empty and almost-full flags.
`timescale 1ns/1ps

module sync_fifo_afe #(
	parameter type payload_t = logic [31:0],
	parameter int depth = 8,
	parameter int almost_full_threshold = 0,
	parameter int almost_empty_threshold = 0
) (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     wr,
	input  payload_t wr_data,
	input  logic     rd,
	output payload_t rd_data,
	output logic     empty,
	output logic     full,
	output logic     almost_empty,
	output logic     almost_full
);

	localparam int idx_w = $clog2(depth);
	localparam int ptr_w = idx_w + 1;

	typedef logic [ptr_w-1:0] ptr_t;

	payload_t mem [depth];

	// pointers carry one extra wrap bit to tell full from empty.
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	ptr_t next_wr_ptr;
	ptr_t next_rd_ptr;
	ptr_t next_count;
	logic next_empty;
	logic next_full;

	assign next_wr_ptr = wr_ptr + ptr_t'(wr);
	assign next_rd_ptr = rd_ptr + ptr_t'(rd);

	// occupancy after this edge, modulo twice the depth.
	assign next_count = next_wr_ptr - next_rd_ptr;

	assign next_empty = (next_wr_ptr == next_rd_ptr);
	assign next_full  = (next_wr_ptr[idx_w-1:0] == next_rd_ptr[idx_w-1:0]) &&
	                    (next_wr_ptr[idx_w] != next_rd_ptr[idx_w]);

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr[idx_w-1:0]] <= wr_data;
		end
	end

	assign rd_data = mem[rd_ptr[idx_w-1:0]];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			wr_ptr <= next_wr_ptr;
			rd_ptr <= next_rd_ptr;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			empty <= 1'b1;
			full  <= 1'b0;
		end else begin
			empty <= next_empty;
			full  <= next_full;
		end
	end

	// the almost flags look at the next occupancy, so they switch on the same edge
	// as empty and full.
	generate
		if (almost_full_threshold == 0) begin : gen_af_off
			assign almost_full = 1'b0;
		end else begin : gen_af_on
			always_ff @(posedge clk or negedge reset_n) begin
				if (!reset_n) begin
					almost_full <= 1'b0;
				end else begin
					almost_full <= !next_full &&
					               (next_count >= ptr_t'(depth - almost_full_threshold));
				end
			end
		end
	endgenerate

	generate
		if (almost_empty_threshold == 0) begin : gen_ae_off
			assign almost_empty = 1'b0;
		end else begin : gen_ae_on
			always_ff @(posedge clk or negedge reset_n) begin
				if (!reset_n) begin
					almost_empty <= 1'b0;
				end else begin
					almost_empty <= !next_empty &&
					                (next_count <= ptr_t'(almost_empty_threshold));
				end
			end
		end
	endgenerate

endmodule

// ==== hdl/wbuf_pkg.sv ====
// Write buffer types for core stores and merged memory writes.
`include "wbuf_macros.svh"

package wbuf_pkg;

	// one store as handed over by the core.
	typedef struct packed {
		logic [`WBUF_ADDR_W-1:0] addr;
		logic [31:0]             data;
		logic [3:0]              be;
	} store_req_t;

	// a merged write as presented to memory.
	typedef struct packed {
		logic [`WBUF_ADDR_W-1:0] addr;
		logic [31:0]             data;
		logic [3:0]              be;
	} mem_wr_t;

endpackage

// ==== hdl/wbuf_macros.svh ====
// Write buffer sizing: FIFO depth, flag thresholds and the word address width.
`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

// number of FIFO entries, which must be a power of two.
`define WBUF_DEPTH 8

// almost-full rises this many entries below full.
// it must cover the intake register plus one store issued as stall rises, so at least 2.
`define WBUF_AF_THRESHOLD 2

// the write buffer does not use almost-empty, so the flag is tied off.
`define WBUF_AE_THRESHOLD 0

// word address width, so byte addresses are two bits wider.
`define WBUF_ADDR_W 30

`endif
